// ==== Bender.yml ====
package:
  name: vector_lane

sources:
  # Packages first, then the datapath blocks
  - files:
      - common/lane_cfg_pkg.sv
      - common/lane_op_pkg.sv
      - vrf/vrf_bank.sv
      - rtl/lane_read_extract.sv
      - rtl/lane_ctrl_pipe.sv
      - rtl/lane_operand_route.sv
      - rtl/lane_write_path.sv
      - rtl/vector_lane.sv

  # Testbench
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_vector_lane.sv

// ==== common/lane_cfg_pkg.sv ====
package lane_cfg_pkg;

   ////////////////////
   // Data types
   ////////////////////

   // One VRF word
   typedef logic [31:0] word_t;

   // Byte position inside a word
   typedef logic [1:0] byte_sel_t;

   // Element width of a read or write
   typedef enum logic [1:0] {
      SEW_8  = 2'b00,
      SEW_16 = 2'b01,
      SEW_32 = 2'b10
   } sew_e;

   ////////////////////
   // Read timing
   ////////////////////

   // Address to raw VRF data
   localparam int VRF_RD_LAT = 2;
   // Address to extracted operand, one more for the element register
   localparam int LANE_RD_LAT = 3;
   // Raw data of this read port leaves as slide data
   localparam int SLIDE_PORT = 1;

endpackage

// ==== common/lane_op_pkg.sv ====
package lane_op_pkg;

   ////////////////////
   // Write side
   ////////////////////

   // Write data source per write port
   typedef enum logic [1:0] {
      SRC_ALU   = 2'b00,
      SRC_LOAD  = 2'b01,
      SRC_SLIDE = 2'b10,
      SRC_ZERO  = 2'b11
   } wdata_src_e;

   ////////////////////
   // ALU side
   ////////////////////

   // Opcode field passed through to the ALU
   localparam int ALU_CTRL_W = 6;

endpackage

// ==== list.f ====
common/lane_cfg_pkg.sv
common/lane_op_pkg.sv
vrf/vrf_bank.sv
rtl/lane_read_extract.sv
rtl/lane_ctrl_pipe.sv
rtl/lane_operand_route.sv
rtl/lane_write_path.sv
rtl/vector_lane.sv
tb/tb_clk_gen.sv
tb/tb_vector_lane.sv

// ==== rtl/lane_ctrl_pipe.sv ====
module lane_ctrl_pipe
   import lane_cfg_pkg::*;
   import lane_op_pkg::*;
#(
   parameter int R_PORTS_NUM = 8,
   parameter int W_PORTS_NUM = 4
) (
   input  logic                                             clk_i,
   input  logic                                             rstn_i,
   input  logic [W_PORTS_NUM-1:0]                           read_data_valid_i,
   input  sew_e [W_PORTS_NUM-1:0]                           read_sew_i,
   input  sew_e [W_PORTS_NUM-1:0]                           write_sew_i,
   input  logic [W_PORTS_NUM-1:0][ALU_CTRL_W-1:0]           alu_ctrl_i,
   input  logic [W_PORTS_NUM-1:0]                           reduction_op_i,
   input  logic [W_PORTS_NUM-1:0][$clog2(R_PORTS_NUM)-1:0]  op3_sel_i,
   input  logic [$clog2(R_PORTS_NUM)-1:0]                   store_data_sel_i,
   input  logic [$clog2(R_PORTS_NUM)-1:0]                   store_index_sel_i,
   input  logic [W_PORTS_NUM-1:0]                           store_data_valid_i,
   input  logic [W_PORTS_NUM-1:0]                           store_index_valid_i,
   output sew_e [W_PORTS_NUM-1:0]                           extract_sew_o,
   output logic [W_PORTS_NUM-1:0]                           alu_vld_o,
   output sew_e [W_PORTS_NUM-1:0]                           alu_read_sew_o,
   output sew_e [W_PORTS_NUM-1:0]                           alu_write_sew_o,
   output logic [W_PORTS_NUM-1:0][ALU_CTRL_W-1:0]           alu_opmode_o,
   output logic [W_PORTS_NUM-1:0]                           alu_reduction_o,
   output logic [W_PORTS_NUM-1:0][$clog2(R_PORTS_NUM)-1:0]  op3_sel_o,
   output logic [$clog2(R_PORTS_NUM)-1:0]                   store_data_sel_o,
   output logic [$clog2(R_PORTS_NUM)-1:0]                   store_index_sel_o,
   output logic [W_PORTS_NUM-1:0]                           store_data_valid_o,
   output logic [W_PORTS_NUM-1:0]                           store_index_valid_o
);

   localparam int SW   = $clog2(R_PORTS_NUM);
   localparam int LAST = LANE_RD_LAT - 1;

   ////////////////////
   // Stage registers
   ////////////////////

   logic [LANE_RD_LAT-1:0][W_PORTS_NUM-1:0]                 vld_q;
   sew_e [LANE_RD_LAT-1:0][W_PORTS_NUM-1:0]                 rsew_q;
   sew_e [LANE_RD_LAT-1:0][W_PORTS_NUM-1:0]                 wsew_q;
   logic [LANE_RD_LAT-1:0][W_PORTS_NUM-1:0][ALU_CTRL_W-1:0] ctrl_q;
   logic [LANE_RD_LAT-1:0][W_PORTS_NUM-1:0]                 red_q;
   logic [LANE_RD_LAT-1:0][W_PORTS_NUM-1:0][SW-1:0]         op3_q;
   logic [LANE_RD_LAT-1:0][SW-1:0]                          sdsel_q;
   logic [LANE_RD_LAT-1:0][SW-1:0]                          sisel_q;
   logic [LANE_RD_LAT-1:0][W_PORTS_NUM-1:0]                 sdvld_q;
   logic [LANE_RD_LAT-1:0][W_PORTS_NUM-1:0]                 sivld_q;

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int s = 0; s < LANE_RD_LAT; s++) begin
            for (int w = 0; w < W_PORTS_NUM; w++) begin
               rsew_q[s][w] <= SEW_8;
               wsew_q[s][w] <= SEW_8;
            end
         end
         vld_q   <= '0;
         ctrl_q  <= '0;
         red_q   <= '0;
         op3_q   <= '0;
         sdsel_q <= '0;
         sisel_q <= '0;
         sdvld_q <= '0;
         sivld_q <= '0;
      end else begin
         // Stage 0 captures the issue cycle
         vld_q[0]   <= read_data_valid_i;
         rsew_q[0]  <= read_sew_i;
         wsew_q[0]  <= write_sew_i;
         ctrl_q[0]  <= alu_ctrl_i;
         red_q[0]   <= reduction_op_i;
         op3_q[0]   <= op3_sel_i;
         sdsel_q[0] <= store_data_sel_i;
         sisel_q[0] <= store_index_sel_i;
         sdvld_q[0] <= store_data_valid_i;
         sivld_q[0] <= store_index_valid_i;
         for (int s = 1; s < LANE_RD_LAT; s++) begin
            vld_q[s]   <= vld_q[s-1];
            rsew_q[s]  <= rsew_q[s-1];
            wsew_q[s]  <= wsew_q[s-1];
            ctrl_q[s]  <= ctrl_q[s-1];
            red_q[s]   <= red_q[s-1];
            op3_q[s]   <= op3_q[s-1];
            sdsel_q[s] <= sdsel_q[s-1];
            sisel_q[s] <= sisel_q[s-1];
            sdvld_q[s] <= sdvld_q[s-1];
            sivld_q[s] <= sivld_q[s-1];
         end
      end
   end

   // Read SEW one stage early, meets raw VRF data
   assign extract_sew_o = rsew_q[LAST-1];

   // Last stage lines up with the operands
   assign alu_vld_o           = vld_q[LAST];
   assign alu_read_sew_o      = rsew_q[LAST];
   assign alu_write_sew_o     = wsew_q[LAST];
   assign alu_opmode_o        = ctrl_q[LAST];
   assign alu_reduction_o     = red_q[LAST];
   assign op3_sel_o           = op3_q[LAST];
   assign store_data_sel_o    = sdsel_q[LAST];
   assign store_index_sel_o   = sisel_q[LAST];
   assign store_data_valid_o  = sdvld_q[LAST];
   assign store_index_valid_o = sivld_q[LAST];

endmodule

// ==== rtl/lane_operand_route.sv ====
module lane_operand_route
   import lane_cfg_pkg::*;
#(
   parameter int R_PORTS_NUM = 8,
   parameter int W_PORTS_NUM = 4
) (
   input  word_t [R_PORTS_NUM-1:0]                          elem_i,
   input  logic [W_PORTS_NUM-1:0][$clog2(R_PORTS_NUM)-1:0]  op3_sel_i,
   input  logic [$clog2(R_PORTS_NUM)-1:0]                   store_data_sel_i,
   input  logic [$clog2(R_PORTS_NUM)-1:0]                   store_index_sel_i,
   output word_t [W_PORTS_NUM-1:0]                          vs1_data_o,
   output word_t [W_PORTS_NUM-1:0]                          vs2_data_o,
   output word_t [W_PORTS_NUM-1:0]                          vs3_data_o,
   output word_t                                            store_data_o,
   output word_t                                            store_index_o
);

   ////////////////////
   // ALU operands
   ////////////////////

   // Fixed pair per write port, vs3 from any port
   always_comb begin
      for (int j = 0; j < W_PORTS_NUM; j++) begin
         vs1_data_o[j] = elem_i[2*j];
         vs2_data_o[j] = elem_i[2*j+1];
         vs3_data_o[j] = elem_i[op3_sel_i[j]];
      end
   end

   ////////////////////
   // Store side
   ////////////////////

   // Store data
   assign store_data_o  = elem_i[store_data_sel_i];
   // Store or load index
   assign store_index_o = elem_i[store_index_sel_i];

endmodule

// ==== rtl/lane_read_extract.sv ====
module lane_read_extract
   import lane_cfg_pkg::*;
(
   input  logic      clk_i,
   input  logic      rstn_i,
   input  word_t     rdata_i,
   input  byte_sel_t byte_sel_i,
   input  sew_e      sew_i,
   output word_t     elem_o
);

   // Byte select travels with the VRF read
   byte_sel_t [VRF_RD_LAT-1:0] sel_q;
   byte_sel_t                  sel;
   word_t                      elem_d;
   word_t                      elem_q;

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         sel_q <= '0;
      end else begin
         sel_q[0] <= byte_sel_i;
         for (int s = 1; s < VRF_RD_LAT; s++) begin
            sel_q[s] <= sel_q[s-1];
         end
      end
   end

   assign sel = sel_q[VRF_RD_LAT-1];

   // Byte, halfword or word, zero-extended
   always_comb begin
      case (sew_i)
         SEW_8:   elem_d = {24'b0, rdata_i[8*sel +: 8]};
         // Halfword picked by low select bit
         SEW_16:  elem_d = {16'b0, rdata_i[16*sel[0] +: 16]};
         default: elem_d = rdata_i;
      endcase
   end

   // Operand register
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         elem_q <= '0;
      end else begin
         elem_q <= elem_d;
      end
   end

   assign elem_o = elem_q;

endmodule

// ==== rtl/lane_write_path.sv ====
module lane_write_path
   import lane_cfg_pkg::*;
   import lane_op_pkg::*;
(
   input  word_t      alu_res_i,
   input  word_t      load_data_i,
   input  word_t      slide_data_i,
   input  wdata_src_e wsrc_i,
   input  logic [3:0] bwen_i,
   input  logic       alu_vld_i,
   input  logic       wr_req_i,
   output word_t      wdata_o,
   output logic [3:0] bwen_o
);

   // Write is valid on an ALU result or an explicit request
   logic wr_vld;

   assign wr_vld = alu_vld_i | wr_req_i;

   ////////////////////
   // Data source mux
   ////////////////////

   always_comb begin
      case (wsrc_i)
         SRC_ALU:   wdata_o = alu_res_i;
         SRC_LOAD:  wdata_o = load_data_i;
         SRC_SLIDE: wdata_o = slide_data_i;
         default:   wdata_o = '0;
      endcase
   end

   // Nothing written without a valid
   assign bwen_o = bwen_i & {4{wr_vld}};

endmodule

// ==== rtl/vector_lane.sv ====
module vector_lane
   import lane_cfg_pkg::*;
   import lane_op_pkg::*;
#(
   parameter int R_PORTS_NUM = 8,
   parameter int W_PORTS_NUM = 4,
   parameter int MEM_DEPTH   = 64
) (
   input  logic                                             clk_i,
   input  logic                                             rstn_i,
   // Read issue
   input  logic [R_PORTS_NUM-1:0][$clog2(MEM_DEPTH)-1:0]    vrf_raddr_i,
   input  byte_sel_t [R_PORTS_NUM-1:0]                      vrf_read_byte_sel_i,
   input  sew_e [W_PORTS_NUM-1:0]                           vrf_read_sew_i,
   input  sew_e [W_PORTS_NUM-1:0]                           vrf_write_sew_i,
   input  logic [W_PORTS_NUM-1:0]                           read_data_valid_i,
   input  logic [W_PORTS_NUM-1:0][ALU_CTRL_W-1:0]           alu_ctrl_i,
   input  logic [W_PORTS_NUM-1:0]                           reduction_op_i,
   input  logic [W_PORTS_NUM-1:0][$clog2(R_PORTS_NUM)-1:0]  op3_sel_i,
   input  logic [$clog2(R_PORTS_NUM)-1:0]                   store_data_sel_i,
   input  logic [$clog2(R_PORTS_NUM)-1:0]                   store_index_sel_i,
   input  logic [W_PORTS_NUM-1:0]                           store_data_valid_i,
   input  logic [W_PORTS_NUM-1:0]                           store_index_valid_i,
   // Write side
   input  logic [W_PORTS_NUM-1:0][$clog2(MEM_DEPTH)-1:0]    vrf_waddr_i,
   input  logic [W_PORTS_NUM-1:0][3:0]                      vrf_bwen_i,
   input  wdata_src_e [W_PORTS_NUM-1:0]                     vrf_wsrc_i,
   input  word_t [W_PORTS_NUM-1:0]                          alu_res_i,
   input  logic [W_PORTS_NUM-1:0]                           alu_vld_i,
   input  logic [W_PORTS_NUM-1:0]                           wr_req_i,
   input  word_t                                            load_data_i,
   input  word_t                                            slide_data_i,
   // ALU side
   output logic [W_PORTS_NUM-1:0][ALU_CTRL_W-1:0]           alu_opmode_o,
   output logic [W_PORTS_NUM-1:0]                           alu_reduction_o,
   output sew_e [W_PORTS_NUM-1:0]                           alu_read_sew_o,
   output sew_e [W_PORTS_NUM-1:0]                           alu_write_sew_o,
   output logic [W_PORTS_NUM-1:0]                           alu_vld_o,
   output word_t [W_PORTS_NUM-1:0]                          vs1_data_o,
   output word_t [W_PORTS_NUM-1:0]                          vs2_data_o,
   output word_t [W_PORTS_NUM-1:0]                          vs3_data_o,
   // Store and slide side
   output word_t                                            store_data_o,
   output word_t                                            store_index_o,
   output logic [W_PORTS_NUM-1:0]                           store_data_valid_o,
   output logic [W_PORTS_NUM-1:0]                           store_index_valid_o,
   output word_t                                            slide_data_o
);

   localparam int SW = $clog2(R_PORTS_NUM);

   // Raw and extracted read data
   word_t [R_PORTS_NUM-1:0]          vrf_rdata;
   word_t [R_PORTS_NUM-1:0]          elem;
   // Control taps
   sew_e [W_PORTS_NUM-1:0]           extract_sew;
   logic [W_PORTS_NUM-1:0][SW-1:0]   op3_sel;
   logic [SW-1:0]                    store_data_sel;
   logic [SW-1:0]                    store_index_sel;
   // Gated write port
   word_t [W_PORTS_NUM-1:0]          vrf_wdata;
   logic [W_PORTS_NUM-1:0][3:0]      vrf_bwen;

   ////////////////////
   // Register file
   ////////////////////

   vrf_bank #(
      .R_PORTS_NUM (R_PORTS_NUM),
      .W_PORTS_NUM (W_PORTS_NUM),
      .MEM_DEPTH   (MEM_DEPTH)
   ) vrf_bank_i (
      .clk_i   (clk_i),
      .rstn_i  (rstn_i),
      .raddr_i (vrf_raddr_i),
      .rdata_o (vrf_rdata),
      .waddr_i (vrf_waddr_i),
      .wdata_i (vrf_wdata),
      .bwen_i  (vrf_bwen)
   );

   // Slide data straight off the VRF
   assign slide_data_o = vrf_rdata[SLIDE_PORT];

   ////////////////////
   // Read path
   ////////////////////

   // Port k uses the SEW of pair k/2
   for (genvar k = 0; k < R_PORTS_NUM; k++) begin : g_rd
      lane_read_extract lane_read_extract_i (
         .clk_i      (clk_i),
         .rstn_i     (rstn_i),
         .rdata_i    (vrf_rdata[k]),
         .byte_sel_i (vrf_read_byte_sel_i[k]),
         .sew_i      (extract_sew[k/2]),
         .elem_o     (elem[k])
      );
   end

   lane_ctrl_pipe #(
      .R_PORTS_NUM (R_PORTS_NUM),
      .W_PORTS_NUM (W_PORTS_NUM)
   ) lane_ctrl_pipe_i (
      .clk_i               (clk_i),
      .rstn_i              (rstn_i),
      .read_data_valid_i   (read_data_valid_i),
      .read_sew_i          (vrf_read_sew_i),
      .write_sew_i         (vrf_write_sew_i),
      .alu_ctrl_i          (alu_ctrl_i),
      .reduction_op_i      (reduction_op_i),
      .op3_sel_i           (op3_sel_i),
      .store_data_sel_i    (store_data_sel_i),
      .store_index_sel_i   (store_index_sel_i),
      .store_data_valid_i  (store_data_valid_i),
      .store_index_valid_i (store_index_valid_i),
      .extract_sew_o       (extract_sew),
      .alu_vld_o           (alu_vld_o),
      .alu_read_sew_o      (alu_read_sew_o),
      .alu_write_sew_o     (alu_write_sew_o),
      .alu_opmode_o        (alu_opmode_o),
      .alu_reduction_o     (alu_reduction_o),
      .op3_sel_o           (op3_sel),
      .store_data_sel_o    (store_data_sel),
      .store_index_sel_o   (store_index_sel),
      .store_data_valid_o  (store_data_valid_o),
      .store_index_valid_o (store_index_valid_o)
   );

   lane_operand_route #(
      .R_PORTS_NUM (R_PORTS_NUM),
      .W_PORTS_NUM (W_PORTS_NUM)
   ) lane_operand_route_i (
      .elem_i            (elem),
      .op3_sel_i         (op3_sel),
      .store_data_sel_i  (store_data_sel),
      .store_index_sel_i (store_index_sel),
      .vs1_data_o        (vs1_data_o),
      .vs2_data_o        (vs2_data_o),
      .vs3_data_o        (vs3_data_o),
      .store_data_o      (store_data_o),
      .store_index_o     (store_index_o)
   );

   ////////////////////
   // Write path
   ////////////////////

   for (genvar j = 0; j < W_PORTS_NUM; j++) begin : g_wr
      lane_write_path lane_write_path_i (
         .alu_res_i    (alu_res_i[j]),
         .load_data_i  (load_data_i),
         .slide_data_i (slide_data_i),
         .wsrc_i       (vrf_wsrc_i[j]),
         .bwen_i       (vrf_bwen_i[j]),
         .alu_vld_i    (alu_vld_i[j]),
         .wr_req_i     (wr_req_i[j]),
         .wdata_o      (vrf_wdata[j]),
         .bwen_o       (vrf_bwen[j])
      );
   end

endmodule

// ==== tb/tb_clk_gen.sv ====
module tb_clk_gen #(
   parameter int PERIOD = 8
) (
   output logic clk_o
);

   // Free-running clock, starts low
   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD / 2) clk_o = ~clk_o;
      end
   end

endmodule

// ==== tb/tb_vector_lane.sv ====
module tb_vector_lane
   import lane_cfg_pkg::*;
   import lane_op_pkg::*;
;

   localparam int R_PORTS_NUM = 8;
   localparam int W_PORTS_NUM = 4;
   localparam int MEM_DEPTH   = 64;
   localparam int AW          = $clog2(MEM_DEPTH);
   localparam int SW          = $clog2(R_PORTS_NUM);
   // Roughly 56 reads of 4 cycles plus 37 writes, well under this
   localparam int MAX_CYCLES  = 2000;

   logic                                 clk_i;
   logic                                 rstn_i;
   logic [R_PORTS_NUM-1:0][AW-1:0]       vrf_raddr_i;
   byte_sel_t [R_PORTS_NUM-1:0]          vrf_read_byte_sel_i;
   sew_e [W_PORTS_NUM-1:0]               vrf_read_sew_i;
   sew_e [W_PORTS_NUM-1:0]               vrf_write_sew_i;
   logic [W_PORTS_NUM-1:0]               read_data_valid_i;
   logic [W_PORTS_NUM-1:0][ALU_CTRL_W-1:0] alu_ctrl_i;
   logic [W_PORTS_NUM-1:0]               reduction_op_i;
   logic [W_PORTS_NUM-1:0][SW-1:0]       op3_sel_i;
   logic [SW-1:0]                        store_data_sel_i;
   logic [SW-1:0]                        store_index_sel_i;
   logic [W_PORTS_NUM-1:0]               store_data_valid_i;
   logic [W_PORTS_NUM-1:0]               store_index_valid_i;
   logic [W_PORTS_NUM-1:0][AW-1:0]       vrf_waddr_i;
   logic [W_PORTS_NUM-1:0][3:0]          vrf_bwen_i;
   wdata_src_e [W_PORTS_NUM-1:0]         vrf_wsrc_i;
   word_t [W_PORTS_NUM-1:0]              alu_res_i;
   logic [W_PORTS_NUM-1:0]               alu_vld_i;
   logic [W_PORTS_NUM-1:0]               wr_req_i;
   word_t                                load_data_i;
   word_t                                slide_data_i;
   logic [W_PORTS_NUM-1:0][ALU_CTRL_W-1:0] alu_opmode_o;
   logic [W_PORTS_NUM-1:0]               alu_reduction_o;
   sew_e [W_PORTS_NUM-1:0]               alu_read_sew_o;
   sew_e [W_PORTS_NUM-1:0]               alu_write_sew_o;
   logic [W_PORTS_NUM-1:0]               alu_vld_o;
   word_t [W_PORTS_NUM-1:0]              vs1_data_o;
   word_t [W_PORTS_NUM-1:0]              vs2_data_o;
   word_t [W_PORTS_NUM-1:0]              vs3_data_o;
   word_t                                store_data_o;
   word_t                                store_index_o;
   logic [W_PORTS_NUM-1:0]               store_data_valid_o;
   logic [W_PORTS_NUM-1:0]               store_index_valid_o;
   word_t                                slide_data_o;

   // Shadow VRF and read issue state
   word_t          shadow [MEM_DEPTH];
   logic [AW-1:0]  rd_addr [R_PORTS_NUM];
   byte_sel_t      rd_sel [R_PORTS_NUM];
   // Read SEW per operand pair
   sew_e           rd_sew [W_PORTS_NUM];
   // Control history, three cycles deep
   logic [2:0][W_PORTS_NUM-1:0]                 vld_hist;
   logic [2:0][W_PORTS_NUM-1:0]                 sdvld_hist;
   logic [2:0][W_PORTS_NUM-1:0]                 sivld_hist;
   logic [2:0][W_PORTS_NUM-1:0]                 red_hist;
   logic [2:0][W_PORTS_NUM-1:0][1:0]            rsew_hist;
   logic [2:0][W_PORTS_NUM-1:0][1:0]            wsew_hist;
   logic [2:0][W_PORTS_NUM-1:0][ALU_CTRL_W-1:0] ctrl_hist;
   // Bookkeeping
   string cur_test;
   int    n_err = 0;
   int    err_at_start;
   int    n_pass = 0;
   int    n_fail = 0;
   int    cycles = 0;
   logic [3:0] pattern;
   logic [AW-1:0] a;
   logic [AW-1:0] wr_addrs [16];

   tb_clk_gen #(.PERIOD(8)) tb_clk_gen_i (.clk_o(clk_i));

   vector_lane vector_lane_i (.*);

   ////////////////////
   // Checking
   ////////////////////

   function automatic void report_mismatch(string what, word_t exp, word_t act);
      n_err++;
      $display("[FAIL] %s %s expected %h actual %h", cur_test, what, exp, act);
   endfunction

   task automatic check_word(input string what, input word_t exp, input word_t act);
      assert (act === exp) else report_mismatch(what, exp, act);
   endtask

   // Element as the SEW rules define it
   function automatic word_t elem_ref(word_t w, sew_e sew, byte_sel_t sel);
      if (sew == SEW_8) begin
         return (w >> (8 * sel)) & 32'h0000_00ff;
      end else if (sew == SEW_16) begin
         return sel[0] ? {16'b0, w[31:16]} : {16'b0, w[15:0]};
      end
      return w;
   endfunction

   // Control must come out three cycles after issue
   always @(posedge clk_i) begin
      if (!rstn_i) begin
         vld_hist   <= '0;
         sdvld_hist <= '0;
         sivld_hist <= '0;
         red_hist   <= '0;
         rsew_hist  <= '0;
         wsew_hist  <= '0;
         ctrl_hist  <= '0;
      end else begin
         vld_hist   <= {vld_hist[1:0], read_data_valid_i};
         sdvld_hist <= {sdvld_hist[1:0], store_data_valid_i};
         sivld_hist <= {sivld_hist[1:0], store_index_valid_i};
         red_hist   <= {red_hist[1:0], reduction_op_i};
         rsew_hist  <= {rsew_hist[1:0], vrf_read_sew_i};
         wsew_hist  <= {wsew_hist[1:0], vrf_write_sew_i};
         ctrl_hist  <= {ctrl_hist[1:0], alu_ctrl_i};
      end
   end

   always @(negedge clk_i) begin
      if (rstn_i) begin
         check_word("alu_vld_o", vld_hist[2], alu_vld_o);
         check_word("store_data_valid_o", sdvld_hist[2], store_data_valid_o);
         check_word("store_index_valid_o", sivld_hist[2], store_index_valid_o);
         check_word("alu_reduction_o", red_hist[2], alu_reduction_o);
         check_word("alu_read_sew_o", rsew_hist[2], alu_read_sew_o);
         check_word("alu_write_sew_o", wsew_hist[2], alu_write_sew_o);
         check_word("alu_opmode_o", ctrl_hist[2], alu_opmode_o);
      end
   end

   // Run limit
   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the tests did not finish", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   ////////////////////
   // Stimulus
   ////////////////////

   task automatic start_test(input string name);
      cur_test = name;
      err_at_start = n_err;
   endtask

   task automatic end_test();
      if (n_err == err_at_start) begin
         n_pass++;
         $display("Test %s: passed", cur_test);
      end else begin
         n_fail++;
         $display("Test %s: failed with %0d errors", cur_test, n_err - err_at_start);
      end
   endtask

   // Fresh control word on every write port
   task automatic randomize_ctrl();
      for (int j = 0; j < W_PORTS_NUM; j++) begin
         vrf_write_sew_i[j] = sew_e'($urandom_range(0, 2));
         alu_ctrl_i[j]      = ALU_CTRL_W'($urandom);
         reduction_op_i[j]  = 1'($urandom);
         op3_sel_i[j]       = SW'($urandom);
      end
      store_data_sel_i    = SW'($urandom);
      store_index_sel_i   = SW'($urandom);
      store_data_valid_i  = 4'($urandom);
      store_index_valid_i = 4'($urandom);
   endtask

   // One write, shadow follows the gating and source rules
   task automatic write_word(input int p, input logic [AW-1:0] addr, input logic [3:0] bwen,
                             input wdata_src_e src, input logic vld, input logic req,
                             input word_t data);
      word_t stored;
      vrf_waddr_i[p] = addr;
      vrf_bwen_i[p]  = bwen;
      vrf_wsrc_i[p]  = src;
      // Unselected sources carry the inverse
      alu_res_i[p]   = (src == SRC_ALU) ? data : ~data;
      load_data_i    = (src == SRC_LOAD) ? data : ~data;
      slide_data_i   = (src == SRC_SLIDE) ? data : ~data;
      alu_vld_i[p]   = vld;
      wr_req_i[p]    = req;
      stored = (src == SRC_ZERO) ? '0 : data;
      if (vld || req) begin
         for (int b = 0; b < 4; b++) begin
            if (bwen[b]) begin
               shadow[addr][8*b +: 8] = stored[8*b +: 8];
            end
         end
      end
      @(posedge clk_i);
      #1;
      alu_vld_i[p]  = 1'b0;
      wr_req_i[p]   = 1'b0;
      vrf_bwen_i[p] = '0;
   endtask

   // Issue rd_addr, rd_sel and rd_sew, check slide at t+2 and operands at t+3
   task automatic read_and_check();
      logic [W_PORTS_NUM-1:0][SW-1:0] op3;
      logic [SW-1:0]                  sd_sel;
      logic [SW-1:0]                  si_sel;
      word_t                          elem [R_PORTS_NUM];
      for (int k = 0; k < R_PORTS_NUM; k++) begin
         vrf_raddr_i[k]         = rd_addr[k];
         vrf_read_byte_sel_i[k] = rd_sel[k];
         elem[k] = elem_ref(shadow[rd_addr[k]], rd_sew[k/2], rd_sel[k]);
      end
      randomize_ctrl();
      for (int j = 0; j < W_PORTS_NUM; j++) begin
         vrf_read_sew_i[j] = rd_sew[j];
      end
      read_data_valid_i = '1;
      op3    = op3_sel_i;
      sd_sel = store_data_sel_i;
      si_sel = store_index_sel_i;
      @(posedge clk_i);
      #1;
      read_data_valid_i = '0;
      randomize_ctrl();
      // Read inputs change after issue, only the issue cycle may count
      for (int j = 0; j < W_PORTS_NUM; j++) begin
         vrf_read_sew_i[j] = sew_e'($urandom_range(0, 2));
      end
      for (int k = 0; k < R_PORTS_NUM; k++) begin
         vrf_raddr_i[k]         = AW'($urandom);
         vrf_read_byte_sel_i[k] = 2'($urandom);
      end
      @(posedge clk_i);
      @(negedge clk_i);
      check_word("slide_data_o", shadow[rd_addr[SLIDE_PORT]], slide_data_o);
      @(posedge clk_i);
      @(negedge clk_i);
      for (int j = 0; j < W_PORTS_NUM; j++) begin
         check_word("vs1_data_o", elem[2*j], vs1_data_o[j]);
         check_word("vs2_data_o", elem[2*j+1], vs2_data_o[j]);
         check_word("vs3_data_o", elem[op3[j]], vs3_data_o[j]);
      end
      check_word("store_data_o", elem[sd_sel], store_data_o);
      check_word("store_index_o", elem[si_sel], store_index_o);
      @(posedge clk_i);
      #1;
   endtask

   task automatic read_same(input logic [AW-1:0] addr, input sew_e sew);
      for (int k = 0; k < R_PORTS_NUM; k++) begin
         rd_addr[k] = addr;
         rd_sel[k]  = 2'($urandom);
      end
      for (int j = 0; j < W_PORTS_NUM; j++) begin
         rd_sew[j] = sew;
      end
      read_and_check();
   endtask

   // Random addresses, selects and a SEW of its own per pair
   task automatic read_random();
      for (int k = 0; k < R_PORTS_NUM; k++) begin
         rd_addr[k] = AW'($urandom);
         rd_sel[k]  = 2'($urandom);
      end
      for (int j = 0; j < W_PORTS_NUM; j++) begin
         rd_sew[j] = sew_e'($urandom_range(0, 2));
      end
      read_and_check();
   endtask

   initial begin
      void'($urandom(9));
      rstn_i              = 1'b0;
      vrf_raddr_i         = '0;
      vrf_read_byte_sel_i = '0;
      read_data_valid_i   = '0;
      alu_ctrl_i          = '0;
      reduction_op_i      = '0;
      op3_sel_i           = '0;
      store_data_sel_i    = '0;
      store_index_sel_i   = '0;
      store_data_valid_i  = '0;
      store_index_valid_i = '0;
      vrf_waddr_i         = '0;
      vrf_bwen_i          = '0;
      alu_res_i           = '0;
      alu_vld_i           = '0;
      wr_req_i            = '0;
      load_data_i         = '0;
      slide_data_i        = '0;
      vrf_read_sew_i      = {W_PORTS_NUM{SEW_8}};
      vrf_write_sew_i     = {W_PORTS_NUM{SEW_8}};
      vrf_wsrc_i          = {W_PORTS_NUM{SRC_ALU}};
      for (int i = 0; i < MEM_DEPTH; i++) begin
         shadow[i] = '0;
      end
      repeat (5) @(posedge clk_i);
      #1;
      rstn_i = 1'b1;

      // 1. Reset values, then one valid pulse
      start_test("reset_alignment");
      @(negedge clk_i);
      check_word("alu_vld_o after reset", '0, alu_vld_o);
      check_word("store_data_valid_o after reset", '0, store_data_valid_o);
      check_word("store_index_valid_o after reset", '0, store_index_valid_o);
      check_word("vs1_data_o after reset", '0, vs1_data_o[0]);
      check_word("slide_data_o after reset", '0, slide_data_o);
      @(posedge clk_i);
      #1;
      pattern = 4'($urandom) | 4'b0001;
      randomize_ctrl();
      read_data_valid_i = pattern;
      @(posedge clk_i);
      #1;
      read_data_valid_i = '0;
      randomize_ctrl();
      @(posedge clk_i);
      @(negedge clk_i);
      check_word("alu_vld_o at t+2", '0, alu_vld_o);
      @(posedge clk_i);
      @(negedge clk_i);
      check_word("alu_vld_o at t+3", pattern, alu_vld_o);
      @(posedge clk_i);
      @(negedge clk_i);
      check_word("alu_vld_o at t+4", '0, alu_vld_o);
      @(posedge clk_i);
      #1;
      end_test();

      // 2. Full words through the ALU source
      start_test("word_round_trip");
      for (int i = 0; i < 16; i++) begin
         wr_addrs[i] = AW'($urandom);
         write_word(i % W_PORTS_NUM, wr_addrs[i], 4'hf, SRC_ALU, 1'b1, 1'b0, $urandom);
      end
      for (int i = 0; i < 8; i++) begin
         for (int k = 0; k < R_PORTS_NUM; k++) begin
            rd_addr[k]     = wr_addrs[$urandom_range(0, 15)];
            rd_sel[k]      = 2'($urandom);
            rd_sew[k / 2]  = SEW_32;
         end
         read_and_check();
      end
      end_test();

      // 3. Bytes and halfwords of a known word
      start_test("element_extract");
      write_word(0, 7, 4'hf, SRC_ALU, 1'b1, 1'b0, 32'ha1b2_c3d4);
      for (int i = 0; i < 6; i++) begin
         for (int k = 0; k < R_PORTS_NUM; k++) begin
            rd_addr[k]     = 7;
            rd_sel[k]      = 2'(i + k);
            rd_sew[k / 2]  = (i < 4) ? SEW_8 : SEW_16;
         end
         read_and_check();
      end
      end_test();

      // 4. Byte enables, no-valid write, other sources
      start_test("write_gating");
      for (int i = 0; i < 8; i++) begin
         a = AW'($urandom);
         write_word(i % W_PORTS_NUM, a, 4'hf, SRC_ALU, 1'b1, 1'b0, $urandom);
         write_word(i % W_PORTS_NUM, a, 4'($urandom_range(1, 14)), SRC_ALU, 1'b1, 1'b0,
                    $urandom);
         read_same(a, SEW_32);
      end
      write_word(1, a, 4'hf, SRC_ALU, 1'b0, 1'b0, $urandom);
      read_same(a, SEW_32);
      write_word(2, a, 4'hf, SRC_LOAD, 1'b0, 1'b1, $urandom);
      read_same(a, SEW_32);
      write_word(3, a, 4'hf, SRC_SLIDE, 1'b0, 1'b1, $urandom);
      read_same(a, SEW_32);
      write_word(0, a, 4'hf, SRC_ZERO, 1'b0, 1'b1, $urandom);
      read_same(a, SEW_32);
      end_test();

      // 5. vs3, store data and store index selects
      start_test("operand_select");
      for (int i = 0; i < 20; i++) begin
         read_random();
      end
      end_test();

      // 6. Raw slide data whatever the SEW
      start_test("slide_output");
      for (int i = 0; i < 10; i++) begin
         read_random();
      end
      end_test();

      $display("Tests passed: %0d, tests failed: %0d, check errors: %0d", n_pass, n_fail, n_err);
      if (n_fail == 0 && n_err == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== vrf/vrf_bank.sv ====
module vrf_bank
   import lane_cfg_pkg::*;
#(
   parameter int R_PORTS_NUM = 8,
   parameter int W_PORTS_NUM = 4,
   parameter int MEM_DEPTH   = 64
) (
   input  logic                                          clk_i,
   input  logic                                          rstn_i,
   input  logic [R_PORTS_NUM-1:0][$clog2(MEM_DEPTH)-1:0] raddr_i,
   output word_t [R_PORTS_NUM-1:0]                       rdata_o,
   input  logic [W_PORTS_NUM-1:0][$clog2(MEM_DEPTH)-1:0] waddr_i,
   input  word_t [W_PORTS_NUM-1:0]                       wdata_i,
   input  logic [W_PORTS_NUM-1:0][3:0]                   bwen_i
);

   localparam int AW = $clog2(MEM_DEPTH);

   // Storage array
   word_t mem [MEM_DEPTH];

   // Read stage 1 address, stage 2 data
   logic [R_PORTS_NUM-1:0][AW-1:0] raddr_q;
   word_t [R_PORTS_NUM-1:0]        rdata_q;

   ////////////////////
   // Write ports
   ////////////////////

   // Later ports override earlier ones on the same byte
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int a = 0; a < MEM_DEPTH; a++) begin
            mem[a] <= '0;
         end
      end else begin
         for (int p = 0; p < W_PORTS_NUM; p++) begin
            for (int b = 0; b < 4; b++) begin
               if (bwen_i[p][b]) begin
                  mem[waddr_i[p]][8*b +: 8] <= wdata_i[p][8*b +: 8];
               end
            end
         end
      end
   end

   ////////////////////
   // Read ports
   ////////////////////

   // Two cycles from address to data
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         raddr_q <= '0;
         rdata_q <= '0;
      end else begin
         raddr_q <= raddr_i;
         for (int p = 0; p < R_PORTS_NUM; p++) begin
            rdata_q[p] <= mem[raddr_q[p]];
         end
      end
   end

   assign rdata_o = rdata_q;

endmodule
